//--- all.f
verilog/gbPkg.sv
verilog/vram.sv
verilog/mmu.sv
verilog/lcdRegs.sv
verilog/bgRenderer.sv
verilog/gpu.sv
verilog/pGB.sv
tb/tbPGB.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tbPGB
FILELIST = all.f
PASS     = test passed
BINARY   = obj_dir/V$(TOP)

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(BINARY): $(FILELIST) $(shell cat $(FILELIST))
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# The run passes only if the pass message appears on a line of its own
sim: $(BINARY)
	@out="$$(./$(BINARY))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf obj_dir

//--- tb/tbPGB.sv
module tbPGB import gbPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int screenHeight = 16;
	localparam int vblankLines  = 2;
	localparam int hblankCycles = 8;
	localparam int frameWords   = screenHeight * 20;
	localparam int waitLimit    = 4000;
	localparam int pollLimit    = 1000;

	logic   iClock;
	logic   rstN;
	addrT   cpuAddr;
	byteT   cpuWriteData;
	logic   cpuWe;
	logic   cpuReadRequest;
	byteT   cpuReadData;
	logic   frameBufferWe;
	fbWordT frameBufferData;
	fbAddrT frameBufferAddr;

	int mismatches = 0;
	int timeouts   = 0;

	// Local copies of what was loaded into VRAM
	byteT tileBytes [64];
	byteT mapBytes [1024];

	// Frame buffer contents, plus the running write number that last touched each word
	fbWordT fbModel [512];
	int     fbStamp [512];
	int     writeCount    = 0;
	int     frameEndCount = 0;

	pGB #(
		.screenHeight(screenHeight),
		.vblankLines (vblankLines),
		.hblankCycles(hblankCycles)
	) uut (
		.iClock         (iClock),
		.rstN           (rstN),
		.cpuAddr        (cpuAddr),
		.cpuWriteData   (cpuWriteData),
		.cpuWe          (cpuWe),
		.cpuReadRequest (cpuReadRequest),
		.cpuReadData    (cpuReadData),
		.frameBufferWe  (frameBufferWe),
		.frameBufferData(frameBufferData),
		.frameBufferAddr(frameBufferAddr)
	);

	initial begin
		iClock = 1'b0;
		forever #2 iClock = ~iClock;
	end

	always @(posedge iClock) begin
		if (frameBufferWe) begin
			writeCount <= writeCount + 1;
			if (frameBufferAddr < 16'd512) begin
				fbModel[frameBufferAddr[8:0]] <= frameBufferData;
				fbStamp[frameBufferAddr[8:0]] <= writeCount + 1;
			end
			// The last word of the visible area marks the end of a frame
			if (frameBufferAddr == fbAddrT'(frameWords - 1))
				frameEndCount <= frameEndCount + 1;
		end
	end

	//////////////////////////////////////////////////
	// Bus driver and checks

	task automatic checkByte(input string name, input byteT got, input byteT expected);
		assert (got === expected)
			else begin
				mismatches++;
				$display("Fail %s: got 0x%h, expected 0x%h", name, got, expected);
			end
	endtask

	task automatic checkWord(input string name, input fbWordT got, input fbWordT expected);
		assert (got === expected)
			else begin
				mismatches++;
				$display("Fail %s: got 0x%h, expected 0x%h", name, got, expected);
			end
	endtask

	task automatic cpuWrite(input addrT addr, input byteT data);
		@(posedge iClock);
		cpuAddr      <= addr;
		cpuWriteData <= data;
		cpuWe        <= 1'b1;
		@(posedge iClock);
		cpuWe <= 1'b0;
	endtask

	// Request is sampled on the second edge and data lands one edge later
	task automatic cpuRead(input addrT addr, output byteT data);
		@(posedge iClock);
		cpuAddr        <= addr;
		cpuReadRequest <= 1'b1;
		@(posedge iClock);
		cpuReadRequest <= 1'b0;
		@(posedge iClock);
		@(negedge iClock);
		data = cpuReadData;
	endtask

	task automatic readExpect(input string name, input addrT addr, input byteT expected);
		byteT value;
		cpuRead(addr, value);
		checkByte(name, value, expected);
	endtask

	task automatic writeReadBack(input string name, input addrT addr, input byteT data);
		cpuWrite(addr, data);
		readExpect(name, addr, data);
	endtask

	task automatic waitFrameEnd();
		int startCount;
		int cycles;
		startCount = frameEndCount;
		cycles = 0;
		while (frameEndCount == startCount && cycles < waitLimit) begin
			@(posedge iClock);
			cycles++;
		end
		if (frameEndCount == startCount) begin
			timeouts++;
			$display("Timeout: frame word %0d was not written within %0d cycles",
				frameWords - 1, waitLimit);
		end
	endtask

	// Polls LY until it equals the target, or until it differs when equal is 0
	task automatic pollLy(input byteT target, input bit equal);
		byteT value;
		int polls;
		polls = 0;
		cpuRead(16'hFF44, value);
		while ((value == target) != equal && polls < pollLimit) begin
			cpuRead(16'hFF44, value);
			polls++;
		end
		if ((value == target) != equal) begin
			timeouts++;
			$display("Timeout: LY never reached the expected line relation to %0d", target);
		end
	endtask

	//////////////////////////////////////////////////
	// Reference model of one background word

	function automatic fbWordT expectedWord(input int y, input int g, input byteT scroll,
		input byteT palette);
		byteT       lineSum;
		int         tile;
		int         fine;
		byteT       lo;
		byteT       hi;
		logic [1:0] color;
		fbWordT     word;
		lineSum = byteT'(y) + scroll;
		fine = int'(lineSum[2:0]);
		tile = int'(mapBytes[int'(lineSum[7:3]) * 32 + g]);
		lo = tileBytes[tile * 16 + fine * 2];
		hi = tileBytes[tile * 16 + fine * 2 + 1];
		// Leftmost pixel comes from bit 7 of both planes
		for (int p = 0; p < 8; p++) begin
			color = {hi[7 - p], lo[7 - p]};
			word[2 * p +: 2] = palette[int'(color) * 2 +: 2];
		end
		return word;
	endfunction

	task automatic compareFrame(input byteT scroll, input byteT palette, input int mark);
		int addr;
		for (int y = 0; y < screenHeight; y++) begin
			for (int g = 0; g < 20; g++) begin
				addr = y * 20 + g;
				assert (fbStamp[addr] > mark)
					else begin
						mismatches++;
						$display("Frame word %0d was not written during this frame", addr);
					end
				checkWord($sformatf("frameBufferData[%0d]", addr), fbModel[addr],
					expectedWord(y, g, scroll, palette));
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests

	task automatic testReset();
		for (int i = 0; i < 50; i++) begin
			@(negedge iClock);
			checkByte("frameBufferWe", {7'b0, frameBufferWe}, 8'h00);
		end
		readExpect("LY", 16'hFF44, 8'h00);
		readExpect("LCDC", 16'hFF40, 8'h00);
		readExpect("BGP", 16'hFF47, 8'hFC);
	endtask

	task automatic testRegisterMap();
		writeReadBack("SCY", 16'hFF42, 8'h5A);
		writeReadBack("SCX", 16'hFF43, 8'h3C);
		writeReadBack("LYC", 16'hFF45, 8'h21);
		writeReadBack("BGP", 16'hFF47, 8'h93);
		writeReadBack("DMA", 16'hFF46, 8'hC1);
		writeReadBack("WX", 16'hFF4B, 8'h07);
		// LY belongs to the line counter
		cpuWrite(16'hFF44, 8'h77);
		readExpect("LY", 16'hFF44, 8'h00);
		writeReadBack("HRAM[FF80]", 16'hFF80, 8'hA5);
		writeReadBack("HRAM[FFFE]", 16'hFFFE, 8'h5C);
		readExpect("cpuReadData at E000", 16'hE000, 8'hFF);
		readExpect("cpuReadData at FF7F", 16'hFF7F, 8'hFF);
	endtask

	task automatic testVramAccess();
		addrT addrs [3];
		byteT values [3];
		addrs[0] = 16'h8000;
		addrs[1] = 16'h8FFF;
		addrs[2] = 16'h9BFF;
		for (int i = 0; i < 3; i++) begin
			values[i] = byteT'($urandom);
			cpuWrite(addrs[i], values[i]);
		end
		for (int i = 0; i < 3; i++)
			readExpect($sformatf("VRAM[%h]", addrs[i]), addrs[i], values[i]);
	endtask

	task automatic testRenderFlat();
		int mark;
		cpuWrite(16'hFF42, 8'h00);
		for (int i = 0; i < 64; i++) begin
			tileBytes[i] = byteT'($urandom);
			cpuWrite(16'h8000 + addrT'(i), tileBytes[i]);
		end
		// Index shifts by one per map row so that a scrolled frame looks different
		for (int i = 0; i < 1024; i++) begin
			mapBytes[i] = byteT'((i + i / 32) % 4);
			cpuWrite(16'h9800 + addrT'(i), mapBytes[i]);
		end
		cpuWrite(16'hFF47, 8'hE4);
		mark = writeCount;
		cpuWrite(16'hFF40, 8'h91);
		waitFrameEnd();
		compareFrame(8'h00, 8'hE4, mark);
	endtask

	task automatic testVerticalScroll();
		int mark;
		cpuWrite(16'hFF42, 8'h08);
		cpuWrite(16'hFF47, 8'h1B);
		// The frame in flight may mix old and new settings
		waitFrameEnd();
		mark = writeCount;
		waitFrameEnd();
		compareFrame(8'h08, 8'h1B, mark);
	endtask

	task automatic testLineTiming();
		byteT value;
		cpuWrite(16'hFF45, 8'h05);
		pollLy(8'd5, 1'b1);
		cpuRead(16'hFF41, value);
		checkByte("STAT coincidence at LY 5", value & 8'h04, 8'h04);
		// A CPU write must not disturb the running line counter
		cpuWrite(16'hFF44, 8'h77);
		readExpect("LY while running", 16'hFF44, 8'h05);
		pollLy(8'd5, 1'b0);
		cpuRead(16'hFF41, value);
		checkByte("STAT coincidence after LY 5", value & 8'h04, 8'h00);
		pollLy(8'd16, 1'b1);
		cpuRead(16'hFF41, value);
		checkByte("STAT mode at LY 16", value & 8'h03, 8'h01);
		pollLy(8'd17, 1'b1);
		cpuRead(16'hFF41, value);
		checkByte("STAT mode at LY 17", value & 8'h03, 8'h01);
	endtask

	initial begin
		void'($urandom(38));
		rstN           <= 1'b0;
		cpuAddr        <= '0;
		cpuWriteData   <= '0;
		cpuWe          <= 1'b0;
		cpuReadRequest <= 1'b0;
		repeat (4) @(posedge iClock);
		rstN <= 1'b1;

		testReset();
		testRegisterMap();
		testVramAccess();
		testRenderFlat();
		testVerticalScroll();
		testLineTiming();

		$display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- verilog/pGB.sv
module pGB import gbPkg::*; #(
	parameter int screenHeight = 144,
	parameter int vblankLines  = 10,
	parameter int hblankCycles = 40
) (
	input  logic   iClock,
	input  logic   rstN,
	input  addrT   cpuAddr,
	input  byteT   cpuWriteData,
	input  logic   cpuWe,
	input  logic   cpuReadRequest,
	output byteT   cpuReadData,
	output logic   frameBufferWe,
	output fbWordT frameBufferData,
	output fbAddrT frameBufferAddr
);

	logic [12:0] vramCpuAddr;
	logic        vramCpuWe;
	byteT        vramCpuWriteData;
	byteT        vramCpuReadData;
	regSelT      regSelect;
	byteT        regWriteData;
	logic        regWe;
	addrT        gpuAddr;
	logic        gpuReadRequest;
	byteT        gpuReadData;

	// LCD registers from the GPU back to the MMU read mux
	byteT lcdc;
	byteT stat;
	byteT scy;
	byteT scx;
	byteT ly;
	byteT lyc;
	byteT dma;
	byteT bgp;
	byteT obp0;
	byteT obp1;
	byteT wy;
	byteT wx;

	mmu memUnit (
		.iClock          (iClock),
		.rstN            (rstN),
		.cpuAddr         (cpuAddr),
		.cpuWe           (cpuWe),
		.cpuReadRequest  (cpuReadRequest),
		.cpuWriteData    (cpuWriteData),
		.cpuReadData     (cpuReadData),
		.vramCpuAddr     (vramCpuAddr),
		.vramCpuWe       (vramCpuWe),
		.vramCpuWriteData(vramCpuWriteData),
		.vramCpuReadData (vramCpuReadData),
		.regSelect       (regSelect),
		.regWriteData    (regWriteData),
		.regWe           (regWe),
		.lcdc            (lcdc),
		.stat            (stat),
		.scy             (scy),
		.scx             (scx),
		.ly              (ly),
		.lyc             (lyc),
		.dma             (dma),
		.bgp             (bgp),
		.obp0            (obp0),
		.obp1            (obp1),
		.wy              (wy),
		.wx              (wx)
	);

	// VRAM only decodes the low 13 bits, the renderer always fetches from 0x8000 up
	vram videoRam (
		.iClock        (iClock),
		.cpuAddr       (vramCpuAddr),
		.cpuWe         (vramCpuWe),
		.cpuWriteData  (vramCpuWriteData),
		.cpuReadData   (vramCpuReadData),
		.gpuAddr       (gpuAddr[12:0]),
		.gpuReadRequest(gpuReadRequest),
		.gpuReadData   (gpuReadData)
	);

	gpu #(
		.screenHeight(screenHeight),
		.vblankLines (vblankLines),
		.hblankCycles(hblankCycles)
	) graphics (
		.iClock         (iClock),
		.rstN           (rstN),
		.regSelect      (regSelect),
		.regWriteData   (regWriteData),
		.regWe          (regWe),
		.lcdc           (lcdc),
		.stat           (stat),
		.scy            (scy),
		.scx            (scx),
		.ly             (ly),
		.lyc            (lyc),
		.dma            (dma),
		.bgp            (bgp),
		.obp0           (obp0),
		.obp1           (obp1),
		.wy             (wy),
		.wx             (wx),
		.gpuAddr        (gpuAddr),
		.gpuReadRequest (gpuReadRequest),
		.gpuReadData    (gpuReadData),
		.frameBufferWe  (frameBufferWe),
		.frameBufferData(frameBufferData),
		.frameBufferAddr(frameBufferAddr)
	);

endmodule

//--- verilog/gpu.sv
module gpu import gbPkg::*; #(
	parameter int screenHeight = 144,
	parameter int vblankLines  = 10,
	parameter int hblankCycles = 40
) (
	input  logic   iClock,
	input  logic   rstN,
	input  regSelT regSelect,
	input  byteT   regWriteData,
	input  logic   regWe,
	output byteT   lcdc,
	output byteT   stat,
	output byteT   scy,
	output byteT   scx,
	output byteT   ly,
	output byteT   lyc,
	output byteT   dma,
	output byteT   bgp,
	output byteT   obp0,
	output byteT   obp1,
	output byteT   wy,
	output byteT   wx,
	output addrT   gpuAddr,
	output logic   gpuReadRequest,
	input  byteT   gpuReadData,
	output logic   frameBufferWe,
	output fbWordT frameBufferData,
	output fbAddrT frameBufferAddr
);

	logic       lineDone;
	logic [1:0] mode;

	lcdRegs #(
		.screenHeight(screenHeight),
		.vblankLines (vblankLines)
	) regs (
		.iClock      (iClock),
		.rstN        (rstN),
		.regSelect   (regSelect),
		.regWriteData(regWriteData),
		.regWe       (regWe),
		.lineDone    (lineDone),
		.mode        (mode),
		.lcdc        (lcdc),
		.stat        (stat),
		.scy         (scy),
		.scx         (scx),
		.ly          (ly),
		.lyc         (lyc),
		.dma         (dma),
		.bgp         (bgp),
		.obp0        (obp0),
		.obp1        (obp1),
		.wy          (wy),
		.wx          (wx)
	);

	bgRenderer #(
		.screenHeight(screenHeight),
		.hblankCycles(hblankCycles)
	) renderer (
		.iClock         (iClock),
		.rstN           (rstN),
		.lcdc           (lcdc),
		.scy            (scy),
		.bgp            (bgp),
		.ly             (ly),
		.gpuAddr        (gpuAddr),
		.gpuReadRequest (gpuReadRequest),
		.gpuReadData    (gpuReadData),
		.frameBufferWe  (frameBufferWe),
		.frameBufferData(frameBufferData),
		.frameBufferAddr(frameBufferAddr),
		.lineDone       (lineDone),
		.mode           (mode)
	);

endmodule

//--- verilog/bgRenderer.sv
module bgRenderer import gbPkg::*; #(
	parameter int screenHeight = 144,
	parameter int hblankCycles = 40
) (
	input  logic       iClock,
	input  logic       rstN,
	input  byteT       lcdc,
	input  byteT       scy,
	input  byteT       bgp,
	input  byteT       ly,
	output addrT       gpuAddr,
	output logic       gpuReadRequest,
	input  byteT       gpuReadData,
	output logic       frameBufferWe,
	output fbWordT     frameBufferData,
	output fbAddrT     frameBufferAddr,
	output logic       lineDone,
	output logic [1:0] mode
);

	localparam int lineCycles = 80 + hblankCycles;
	localparam int countWidth = $clog2(lineCycles);
	localparam logic [4:0] lastGroup = 5'd19;
	localparam logic [countWidth-1:0] hblankLast = countWidth'(hblankCycles - 1);
	localparam logic [countWidth-1:0] vblankLast = countWidth'(lineCycles - 1);
	localparam byteT lastVisibleLine = byteT'(screenHeight - 1);
	localparam fbAddrT wordsPerLine = 16'd20;

	renderStateT           state;
	logic [4:0]            group;
	logic [countWidth-1:0] cycleCount;
	byteT                  tileIndex;
	byteT                  lowPlane;
	byteT                  lineSum;
	logic [4:0]            tileRow;
	logic [2:0]            fineRow;

	// Background line after vertical scroll, wrapping over the 256-line map
	assign lineSum = ly + scy;
	assign tileRow = lineSum[7:3];
	assign fineRow = lineSum[2:0];

	//////////////////////////////////////////////////
	// VRAM fetch

	// In sTileLo the map byte is on gpuReadData, in sTileHi the low plane is
	always_comb begin
		case (state)
			sMap:    gpuAddr = 16'h9800 + addrT'({tileRow, group});
			sTileLo: gpuAddr = 16'h8000 + addrT'({gpuReadData, fineRow, 1'b0});
			sTileHi: gpuAddr = 16'h8000 + addrT'({tileIndex, fineRow, 1'b1});
			default: gpuAddr = 16'h0000;
		endcase
	end

	assign gpuReadRequest = state inside {sMap, sTileLo, sTileHi};

	always_ff @(posedge iClock) begin
		if (state == sTileLo)
			tileIndex <= gpuReadData;
		if (state == sTileHi)
			lowPlane <= gpuReadData;
	end

	//////////////////////////////////////////////////
	// Pixel packing

	// Leftmost pixel is the MSB of each plane and lands in bits 1:0
	always_comb begin
		logic [1:0] color;
		for (int p = 0; p < 8; p++) begin
			color = {gpuReadData[7 - p], lowPlane[7 - p]};
			frameBufferData[2*p +: 2] = bgp[2*color +: 2];
		end
	end

	assign frameBufferWe   = state == sWrite;
	assign frameBufferAddr = fbAddrT'(ly) * wordsPerLine + fbAddrT'(group);

	assign lineDone = (state == sHblank && cycleCount == hblankLast) ||
		(state == sVblank && cycleCount == vblankLast);

	always_comb begin
		case (state)
			sMap, sTileLo, sTileHi, sWrite: mode = 2'd3;
			sVblank: mode = 2'd1;
			default: mode = 2'd0;
		endcase
	end

	//////////////////////////////////////////////////
	// Line sequencing

	always_ff @(posedge iClock or negedge rstN) begin
		if (!rstN) begin
			state      <= sIdle;
			group      <= 5'd0;
			cycleCount <= '0;
		end else if (!lcdc[7]) begin
			state      <= sIdle;
			group      <= 5'd0;
			cycleCount <= '0;
		end else begin
			case (state)
				sIdle:   state <= sMap;
				sMap:    state <= sTileLo;
				sTileLo: state <= sTileHi;
				sTileHi: state <= sWrite;
				sWrite: begin
					if (group == lastGroup) begin
						group      <= 5'd0;
						cycleCount <= '0;
						state      <= sHblank;
					end else begin
						group <= group + 5'd1;
						state <= sMap;
					end
				end
				sHblank: begin
					if (cycleCount == hblankLast) begin
						cycleCount <= '0;
						state      <= (ly == lastVisibleLine) ? sVblank : sMap;
					end else begin
						cycleCount <= cycleCount + 1'b1;
					end
				end
				sVblank: begin
					// LY wraps in the register bank, which ends the blank period
					if (ly == 8'd0) begin
						state <= sMap;
					end else if (cycleCount == vblankLast) begin
						cycleCount <= '0;
					end else begin
						cycleCount <= cycleCount + 1'b1;
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

	writeOnVisibleLine: assert property (@(posedge iClock) disable iff (!rstN)
		frameBufferWe |-> ly <= lastVisibleLine)
		else $error("Frame buffer write on blank line %0d", ly);

endmodule

//--- verilog/lcdRegs.sv
module lcdRegs import gbPkg::*; #(
	parameter int screenHeight = 144,
	parameter int vblankLines  = 10
) (
	input  logic       iClock,
	input  logic       rstN,
	input  regSelT     regSelect,
	input  byteT       regWriteData,
	input  logic       regWe,
	input  logic       lineDone,
	input  logic [1:0] mode,
	output byteT       lcdc,
	output byteT       stat,
	output byteT       scy,
	output byteT       scx,
	output byteT       ly,
	output byteT       lyc,
	output byteT       dma,
	output byteT       bgp,
	output byteT       obp0,
	output byteT       obp1,
	output byteT       wy,
	output byteT       wx
);

	localparam byteT lastLine = byteT'(screenHeight + vblankLines - 1);

	logic [3:0] statBits;
	logic       coincidence;

	assign coincidence = ly == lyc;

	// Bit 7 reads as zero, bits 2:0 come from the line timing
	assign stat = {1'b0, statBits, coincidence, mode};

	always_ff @(posedge iClock or negedge rstN) begin
		if (!rstN) begin
			lcdc     <= 8'h00;
			statBits <= 4'h0;
			scy      <= 8'h00;
			scx      <= 8'h00;
			ly       <= 8'h00;
			lyc      <= 8'h00;
			dma      <= 8'h00;
			bgp      <= 8'hFC;
			obp0     <= 8'h00;
			obp1     <= 8'h00;
			wy       <= 8'h00;
			wx       <= 8'h00;
		end else begin
			if (regWe) begin
				case (regSelect)
					regLcdc: lcdc     <= regWriteData;
					regStat: statBits <= regWriteData[6:3];
					regScy:  scy      <= regWriteData;
					regScx:  scx      <= regWriteData;
					// LY is driven by the line counter only
					regLy:   ;
					regLyc:  lyc      <= regWriteData;
					regDma:  dma      <= regWriteData;
					regBgp:  bgp      <= regWriteData;
					regObp0: obp0     <= regWriteData;
					regObp1: obp1     <= regWriteData;
					regWy:   wy       <= regWriteData;
					regWx:   wx       <= regWriteData;
					default: ;
				endcase
			end

			// Line counter holds at zero while the display is off
			if (!lcdc[7])
				ly <= 8'h00;
			else if (lineDone)
				ly <= (ly == lastLine) ? 8'h00 : ly + 8'd1;
		end
	end

endmodule

//--- verilog/mmu.sv
module mmu import gbPkg::*; (
	input  logic        iClock,
	input  logic        rstN,
	input  addrT        cpuAddr,
	input  logic        cpuWe,
	input  logic        cpuReadRequest,
	input  byteT        cpuWriteData,
	output byteT        cpuReadData,
	output logic [12:0] vramCpuAddr,
	output logic        vramCpuWe,
	output byteT        vramCpuWriteData,
	input  byteT        vramCpuReadData,
	output regSelT      regSelect,
	output byteT        regWriteData,
	output logic        regWe,
	input  byteT        lcdc,
	input  byteT        stat,
	input  byteT        scy,
	input  byteT        scx,
	input  byteT        ly,
	input  byteT        lyc,
	input  byteT        dma,
	input  byteT        bgp,
	input  byteT        obp0,
	input  byteT        obp1,
	input  byteT        wy,
	input  byteT        wx
);

	typedef enum logic [1:0] {
		regionVram,
		regionHram,
		regionLcd,
		regionNone
	} regionT;

	regionT     region;
	regionT     readRegion;
	logic       readPending;
	byteT       localData;
	byteT       regReadData;
	logic [6:0] hramIndex;
	byteT       hram [0:126];

	//////////////////////////////////////////////////
	// Address decode

	// 0xFFFF is the interrupt enable on the real part and stays unmapped here
	always_comb begin
		if (cpuAddr[15:13] == 3'b100)
			region = regionVram;
		else if (cpuAddr[15:7] == 9'h1FF && cpuAddr[6:0] != 7'h7F)
			region = regionHram;
		else if (cpuAddr[15:4] == 12'hFF4 && cpuAddr[3:0] <= regWx)
			region = regionLcd;
		else
			region = regionNone;
	end

	assign hramIndex        = cpuAddr[6:0];
	assign vramCpuAddr      = cpuAddr[12:0];
	assign vramCpuWe        = cpuWe && region == regionVram;
	assign vramCpuWriteData = cpuWriteData;
	assign regSelect        = cpuAddr[3:0];
	assign regWriteData     = cpuWriteData;
	assign regWe            = cpuWe && region == regionLcd;

	always_comb begin
		case (regSelect)
			regLcdc: regReadData = lcdc;
			regStat: regReadData = stat;
			regScy:  regReadData = scy;
			regScx:  regReadData = scx;
			regLy:   regReadData = ly;
			regLyc:  regReadData = lyc;
			regDma:  regReadData = dma;
			regBgp:  regReadData = bgp;
			regObp0: regReadData = obp0;
			regObp1: regReadData = obp1;
			regWy:   regReadData = wy;
			regWx:   regReadData = wx;
			default: regReadData = 8'hFF;
		endcase
	end

	//////////////////////////////////////////////////
	// Read path

	// Local sources are captured with the request, VRAM data arrives a cycle later
	always_ff @(posedge iClock) begin
		if (cpuWe && region == regionHram)
			hram[hramIndex] <= cpuWriteData;
		if (cpuReadRequest) begin
			case (region)
				regionHram: localData <= hram[hramIndex];
				regionLcd:  localData <= regReadData;
				default:    localData <= 8'hFF;
			endcase
		end
	end

	always_ff @(posedge iClock or negedge rstN) begin
		if (!rstN) begin
			readPending <= 1'b0;
			readRegion  <= regionNone;
			cpuReadData <= 8'hFF;
		end else begin
			readPending <= cpuReadRequest;
			if (cpuReadRequest)
				readRegion <= region;
			if (readPending)
				cpuReadData <= (readRegion == regionVram) ? vramCpuReadData : localData;
		end
	end

	noReadDuringWrite: assert property (@(posedge iClock) disable iff (!rstN)
		!(cpuWe && cpuReadRequest))
		else $error("CPU read and write requested together at %h", cpuAddr);

endmodule

//--- verilog/vram.sv
module vram import gbPkg::*; #(
	parameter int depth = 8192,
	localparam int addrWidth = $clog2(depth)
) (
	input  logic                 iClock,
	input  logic [addrWidth-1:0] cpuAddr,
	input  logic                 cpuWe,
	input  byteT                 cpuWriteData,
	output byteT                 cpuReadData,
	input  logic [addrWidth-1:0] gpuAddr,
	input  logic                 gpuReadRequest,
	output byteT                 gpuReadData
);

	byteT mem [depth];

	// CPU port reads every cycle and returns the old byte on a write
	always_ff @(posedge iClock) begin
		if (cpuWe)
			mem[cpuAddr] <= cpuWriteData;
		cpuReadData <= mem[cpuAddr];
	end

	// A CPU write to the same address wins over the stored byte
	always_ff @(posedge iClock) begin
		if (gpuReadRequest) begin
			if (cpuWe && cpuAddr == gpuAddr)
				gpuReadData <= cpuWriteData;
			else
				gpuReadData <= mem[gpuAddr];
		end
	end

	cpuWriteInRange: assert property (@(posedge iClock) cpuWe |-> int'(cpuAddr) < depth)
		else $error("VRAM write beyond depth at %h", cpuAddr);

endmodule

//--- verilog/gbPkg.sv
package gbPkg;

	// Bus and frame-buffer widths
	typedef logic [15:0] addrT;
	typedef logic [7:0]  byteT;
	typedef logic [3:0]  regSelT;
	typedef logic [15:0] fbWordT;
	typedef logic [15:0] fbAddrT;

	// LCD register offsets from 0xFF40
	localparam regSelT regLcdc = 4'd0;
	localparam regSelT regStat = 4'd1;
	localparam regSelT regScy  = 4'd2;
	localparam regSelT regScx  = 4'd3;
	localparam regSelT regLy   = 4'd4;
	localparam regSelT regLyc  = 4'd5;
	localparam regSelT regDma  = 4'd6;
	localparam regSelT regBgp  = 4'd7;
	localparam regSelT regObp0 = 4'd8;
	localparam regSelT regObp1 = 4'd9;
	localparam regSelT regWy   = 4'd10;
	localparam regSelT regWx   = 4'd11;

	typedef enum logic [2:0] {
		sIdle,
		sMap,
		sTileLo,
		sTileHi,
		sWrite,
		sHblank,
		sVblank
	} renderStateT;

endpackage
